// ==== Bender.yml ====
package:
  name: board_harness

sources:
  # Packages first, then the blocks and the top level.
  - hdl/board_pkg.sv
  - hdl/fault_pkg.sv
  - hdl/i2c_pad_resolve.sv
  - hdl/fault_first_capture.sv
  - hdl/gpo_pin_split.sv
  - hdl/board_harness_top.sv
  - target: simulation
    files:
      - sim/board_harness_chk.sv
      - sim/tb_board_harness.sv

// ==== filelist.f ====
hdl/board_pkg.sv
hdl/fault_pkg.sv
hdl/i2c_pad_resolve.sv
hdl/fault_first_capture.sv
hdl/gpo_pin_split.sv
hdl/board_harness_top.sv
sim/board_harness_chk.sv
sim/tb_board_harness.sv

// ==== hdl/board_harness_top.sv ====
/*
 * Board harness top level.
 * Joins I2C resolution, fault capture and the output pin split
 * between the system outputs and the board device models.
 */
`timescale 1ns/10ps
`default_nettype none

module board_harness_top import board_pkg::*, fault_pkg::*; #(
  // Number of fault flags, at most 16.
  parameter int unsigned FaultWidth = 9,
  // Number of I2C buses.
  parameter int unsigned I2cBuses   = 2
) (
  input  wire logic                      clk_i,
  input  wire logic                      rst_ni,

  // General-purpose output word and the board pins.
  input  wire gpo_word_u                 gp_i,
  output      gpo_pins_t                 pins_o,

  // I2C controller drives and device pull-downs.
  input  wire i2c_drive_t [I2cBuses-1:0] drive_i,
  input  wire i2c_line_t  [I2cBuses-1:0] dev_pull_i,
  output      i2c_line_t  [I2cBuses-1:0] bus_o,
  output      i2c_line_t  [I2cBuses-1:0] ctrl_line_o,

  // Fault flags and their records.
  input  wire logic [FaultWidth-1:0]     fault_i,
  input  wire logic                      fault_clear_i,
  output      logic                      rec_valid_o,
  output      fault_rec_t                rec_o,
  output      logic [FaultWidth-1:0]     seen_o
);

  // Open-drain buses.
  // Bus level is combinational, controller copy is two flops late.
  i2c_pad_resolve #(
    .I2cBuses    (I2cBuses)
  ) u_i2c_pad_resolve (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .drive_i     (drive_i),
    .dev_pull_i  (dev_pull_i),
    .bus_o       (bus_o),
    .ctrl_line_o (ctrl_line_o)
  );

  // Fault flags are modulated LED drives.
  // Only the first pulse of each kind is reported.
  fault_first_capture #(
    .FaultWidth    (FaultWidth)
  ) u_fault_first_capture (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .fault_i       (fault_i),
    .fault_clear_i (fault_clear_i),
    .rec_valid_o   (rec_valid_o),
    .rec_o         (rec_o),
    .seen_o        (seen_o)
  );

  // Named board pins, one cycle after the word.
  gpo_pin_split u_gpo_pin_split (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .gp_i   (gp_i),
    .pins_o (pins_o)
  );

endmodule

`default_nettype wire

// ==== hdl/board_pkg.sv ====
/*
 * Board pin package.
 * Layout of the general-purpose output word, its two views,
 * and the I2C drive and line bundles.
 */
`default_nettype none

package board_pkg;

  // Width of the general-purpose output word, fixed by the board.
  localparam int unsigned GpoWidth = 23;

  // Board pins in the output word, MSB first.
  typedef struct packed {
    logic       mb_rst;
    logic       mb_cs_n;
    logic       ard_cs_n;
    logic [2:0] rpi_spi1_cs_n;
    logic [1:0] rpi_spi0_cs_n;
    logic       eth_rst_n;
    logic       eth_cs_n;
    logic       flash_cs_n;
    logic [7:0] usr_led;
    logic       lcd_backlight;
    logic       lcd_dc;
    logic       lcd_rst_n;
    logic       lcd_cs_n;
  } gpo_pins_t;

  // Raw word as the system drives it, or the pins as the board reads them.
  typedef union packed {
    logic [GpoWidth-1:0] raw;
    gpo_pins_t           pins;
  } gpo_word_u;

  // Inactive pin levels.
  // Selects deasserted, resets held, LEDs dark.
  localparam gpo_pins_t GpoPinsIdle = '{
    mb_rst:        1'b1,
    mb_cs_n:       1'b1,
    ard_cs_n:      1'b1,
    rpi_spi1_cs_n: 3'b111,
    rpi_spi0_cs_n: 2'b11,
    eth_rst_n:     1'b0,
    eth_cs_n:      1'b1,
    flash_cs_n:    1'b1,
    usr_led:       8'h00,
    lcd_backlight: 1'b0,
    lcd_dc:        1'b0,
    lcd_rst_n:     1'b0,
    lcd_cs_n:      1'b1
  };

  // Controller side of one I2C bus.
  typedef struct packed {
    logic scl;
    logic scl_oe;
    logic sda;
    logic sda_oe;
  } i2c_drive_t;

  // Level of a bus, or a device pull-down where 1 means released.
  typedef struct packed {
    logic scl;
    logic sda;
  } i2c_line_t;

endpackage

`default_nettype wire

// ==== hdl/fault_first_capture.sv ====
/*
 * First-occurrence fault capture.
 * Flags each fault kind once until cleared and issues one
 * timestamped record per cycle, lowest index first.
 */
`timescale 1ns/10ps
`default_nettype none

module fault_first_capture import fault_pkg::*; #(
  parameter int unsigned FaultWidth = 9
) (
  input  wire logic                  clk_i,
  input  wire logic                  rst_ni,
  input  wire logic [FaultWidth-1:0] fault_i,
  input  wire logic                  fault_clear_i,
  output      logic                  rec_valid_o,
  output      fault_rec_t            rec_o,
  output      logic [FaultWidth-1:0] seen_o
);

  // Free-running cycle count.
  logic [StampWidth-1:0] cnt_q;

  // Sticky seen mask and the faults still to be issued.
  logic [FaultWidth-1:0] seen_q;
  logic [FaultWidth-1:0] pend_q;

  // Stamp of the edge that first saw each fault.
  logic [StampWidth-1:0] stamp_q [FaultWidth];

  // Output record.
  logic       rec_valid_q;
  fault_rec_t rec_q;

  logic [FaultWidth-1:0] new_w;
  logic [FaultWidth-1:0] issue_w;
  logic [KindWidth-1:0]  pick_idx;
  logic                  pick_valid;

  // High now, and neither reported nor waiting.
  assign new_w = fault_i & ~seen_q & ~pend_q;

  // Lowest-index pending fault wins.
  // Descending scan so the last hit is the lowest.
  always_comb begin
    pick_idx   = '0;
    pick_valid = 1'b0;
    for (int i = FaultWidth - 1; i >= 0; i--) begin
      if (pend_q[i]) begin
        pick_idx   = KindWidth'(i);
        pick_valid = 1'b1;
      end
    end
  end

  assign issue_w = pick_valid ? (FaultWidth'(1) << pick_idx) : '0;

  // Counter runs from reset, 0 at the first edge.
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  // Seen, pending and record strobe.
  // Clear wins over new faults and over issue.
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      seen_q      <= '0;
      pend_q      <= '0;
      rec_valid_q <= 1'b0;
    end else if (fault_clear_i) begin
      seen_q      <= '0;
      pend_q      <= '0;
      rec_valid_q <= 1'b0;
    end else begin
      seen_q      <= seen_q | new_w;
      pend_q      <= (pend_q & ~issue_w) | new_w;
      rec_valid_q <= pick_valid;
    end
  end

  // Stamps for newly seen faults.
  always_ff @(posedge clk_i) begin
    for (int i = 0; i < FaultWidth; i++) begin
      if (new_w[i] && !fault_clear_i) begin
        stamp_q[i] <= cnt_q;
      end
    end
  end

  // Record payload, loaded with each issue.
  always_ff @(posedge clk_i) begin
    if (pick_valid) begin
      rec_q.kind  <= fault_kind_e'(pick_idx);
      rec_q.stamp <= stamp_q[pick_idx];
    end
  end

  assign rec_valid_o = rec_valid_q;
  assign rec_o       = rec_q;
  assign seen_o      = seen_q;

endmodule

`default_nettype wire

// ==== hdl/fault_pkg.sv ====
/*
 * Fault capture package.
 * Fault kinds in flag order and the timestamped fault record.
 */
`default_nettype none

package fault_pkg;

  // Width of the cycle stamp.
  localparam int unsigned StampWidth = 32;

  // Flag index of each fault kind.
  typedef enum logic [3:0] {
    FaultBounds              = 4'd0,
    FaultTag                 = 4'd1,
    FaultSeal                = 4'd2,
    FaultPermitExecute       = 4'd3,
    FaultPermitLoad          = 4'd4,
    FaultPermitStore         = 4'd5,
    FaultPermitStoreCap      = 4'd6,
    FaultPermitStoreLocalCap = 4'd7,
    FaultPermitSysReg        = 4'd8
  } fault_kind_e;

  // Width of the kind field.
  // Also the width of a flag index.
  localparam int unsigned KindWidth = $bits(fault_kind_e);

  // One reported fault.
  // Stamp is the cycle count of the edge that first saw the flag.
  typedef struct packed {
    fault_kind_e           kind;
    logic [StampWidth-1:0] stamp;
  } fault_rec_t;

endpackage

`default_nettype wire

// ==== hdl/gpo_pin_split.sv ====
/*
 * General-purpose output pin split.
 * Registers the output word through its pin view so every
 * board pin leaves a flop.
 */
`timescale 1ns/10ps
`default_nettype none

module gpo_pin_split import board_pkg::*; (
  input  wire logic      clk_i,
  input  wire logic      rst_ni,
  input  wire gpo_word_u gp_i,
  output      gpo_pins_t pins_o
);

  // Pin register.
  // Chip selects come straight from a flop, free of glitches.
  gpo_pins_t pins_q;

  // Each field resets to its inactive level.
  // Selects high, device resets held, LEDs off.
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pins_q <= GpoPinsIdle;
    end else begin
      // Pin view of the word.
      pins_q <= gp_i.pins;
    end
  end

  assign pins_o = pins_q;

endmodule

`default_nettype wire

// ==== hdl/i2c_pad_resolve.sv ====
/*
 * I2C open-drain resolution.
 * Wired-AND of controller drive and device pull-down per bus,
 * with a two-flop synchroniser back to the controller.
 */
`timescale 1ns/10ps
`default_nettype none

module i2c_pad_resolve import board_pkg::*; #(
  parameter int unsigned I2cBuses = 2
) (
  input  wire logic                      clk_i,
  input  wire logic                      rst_ni,
  input  wire i2c_drive_t [I2cBuses-1:0] drive_i,
  input  wire i2c_line_t  [I2cBuses-1:0] dev_pull_i,
  output      i2c_line_t  [I2cBuses-1:0] bus_o,
  output      i2c_line_t  [I2cBuses-1:0] ctrl_line_o
);

  i2c_line_t [I2cBuses-1:0] bus_w;
  i2c_line_t [I2cBuses-1:0] sync1_q;
  i2c_line_t [I2cBuses-1:0] sync2_q;

  // Resolve each bus.
  // A line without its enable is released, so it reads high.
  always_comb begin
    for (int b = 0; b < I2cBuses; b++) begin
      bus_w[b].scl = (drive_i[b].scl_oe ? drive_i[b].scl : 1'b1) & dev_pull_i[b].scl;
      bus_w[b].sda = (drive_i[b].sda_oe ? drive_i[b].sda : 1'b1) & dev_pull_i[b].sda;
    end
  end

  // Device models see the bus in the same cycle.
  assign bus_o = bus_w;

  // Two stages back to the controller.
  // Reset to released, as the pull-ups would hold it.
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      sync1_q <= '1;
      sync2_q <= '1;
    end else begin
      sync1_q <= bus_w;
      sync2_q <= sync1_q;
    end
  end

  assign ctrl_line_o = sync2_q;

endmodule

`default_nettype wire

// ==== sim/board_harness_chk.sv ====
/*
 * Fault capture checker.
 * Records must follow a seen flag, never repeat before a clear,
 * and stay quiet while in reset.
 */
`timescale 1ns/10ps
`default_nettype none

module board_harness_chk import fault_pkg::*; #(
  parameter int unsigned FaultWidth = 9
) (
  input wire logic                  clk_i,
  input wire logic                  rst_ni,
  input wire logic                  fault_clear_i,
  input wire logic                  rec_valid_i,
  input wire fault_rec_t            rec_i,
  input wire logic [FaultWidth-1:0] seen_i
);

  // Seen mask one cycle back.
  logic [FaultWidth-1:0] seen_prev_q;
  // Kinds reported since the last clear.
  logic [15:0]           reported_q;
  // Number of failed assertions.
  int unsigned           fail_cnt = 0;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      seen_prev_q <= '0;
      reported_q  <= '0;
    end else begin
      seen_prev_q <= seen_i;
      if (fault_clear_i) begin
        reported_q <= '0;
      end else if (rec_valid_i) begin
        reported_q[rec_i.kind] <= 1'b1;
      end
    end
  end

  // Kind must already be flagged when it is issued.
  rec_follows_seen: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rec_valid_i |-> seen_prev_q[rec_i.kind])
    else begin
      $error("record of kind %0d issued without a seen flag", rec_i.kind);
      fail_cnt++;
    end

  // One record per kind until cleared.
  rec_no_repeat: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rec_valid_i |-> !reported_q[rec_i.kind])
    else begin
      $error("kind %0d reported twice without a clear", rec_i.kind);
      fail_cnt++;
    end

  // Strobe low and mask empty during reset.
  quiet_in_reset: assert property (@(posedge clk_i)
    !rst_ni |-> (!rec_valid_i && (seen_i == '0)))
    else begin
      $error("fault capture active while in reset");
      fail_cnt++;
    end

endmodule

bind fault_first_capture board_harness_chk #(
  .FaultWidth    (FaultWidth)
) u_board_harness_chk (
  .clk_i         (clk_i),
  .rst_ni        (rst_ni),
  .fault_clear_i (fault_clear_i),
  .rec_valid_i   (rec_valid_o),
  .rec_i         (rec_o),
  .seen_i        (seen_o)
);

`default_nettype wire

// ==== sim/tb_board_harness.sv ====
/*
 * Board harness testbench.
 * Random pin words, I2C drives and fault pulses checked against
 * models of the pin layout, the wired-AND and the capture rules.
 */
`timescale 1ns/10ps
`default_nettype none

module tb_board_harness import board_pkg::*, fault_pkg::*; ();

  localparam int unsigned FaultWidth = 9;
  localparam int unsigned I2cBuses   = 2;

  // Expected record and the cycle count at which it shows.
  typedef struct packed {
    fault_rec_t  rec;
    logic [31:0] at;
  } exp_rec_t;

  logic                      clk_i;
  logic                      rst_ni;
  gpo_word_u                 gp_i;
  gpo_pins_t                 pins_o;
  i2c_drive_t [I2cBuses-1:0] drive_i;
  i2c_line_t  [I2cBuses-1:0] dev_pull_i;
  i2c_line_t  [I2cBuses-1:0] bus_o;
  i2c_line_t  [I2cBuses-1:0] ctrl_line_o;
  logic [FaultWidth-1:0]     fault_i;
  logic                      fault_clear_i;
  logic                      rec_valid_o;
  fault_rec_t                rec_o;
  logic [FaultWidth-1:0]     seen_o;

  // Edges since reset release.
  // Equals the stamp of the next edge.
  logic [31:0]           cyc;
  logic [FaultWidth-1:0] model_seen;
  exp_rec_t              exp_q [$];
  exp_rec_t              head;
  int unsigned           chk_cnt;
  int unsigned           err_cnt;
  int unsigned           test_err_base;

  board_harness_top #(
    .FaultWidth    (FaultWidth),
    .I2cBuses      (I2cBuses)
  ) u_dut (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .gp_i          (gp_i),
    .pins_o        (pins_o),
    .drive_i       (drive_i),
    .dev_pull_i    (dev_pull_i),
    .bus_o         (bus_o),
    .ctrl_line_o   (ctrl_line_o),
    .fault_i       (fault_i),
    .fault_clear_i (fault_clear_i),
    .rec_valid_o   (rec_valid_o),
    .rec_o         (rec_o),
    .seen_o        (seen_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    if (rst_ni) begin
      cyc <= cyc + 1;
    end
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Board reading of the word, bit by bit from the pin table.
  function automatic gpo_pins_t pin_view(input logic [GpoWidth-1:0] w);
    gpo_pins_t p;
    p.mb_rst        = w[22];
    p.mb_cs_n       = w[21];
    p.ard_cs_n      = w[20];
    p.rpi_spi1_cs_n = w[19:17];
    p.rpi_spi0_cs_n = w[16:15];
    p.eth_rst_n     = w[14];
    p.eth_cs_n      = w[13];
    p.flash_cs_n    = w[12];
    p.usr_led       = w[11:4];
    p.lcd_backlight = w[3];
    p.lcd_dc        = w[2];
    p.lcd_rst_n     = w[1];
    p.lcd_cs_n      = w[0];
    return p;
  endfunction

  // Either side pulling low wins over a released line.
  function automatic i2c_line_t wired_and(input i2c_drive_t d, input i2c_line_t p);
    i2c_line_t r;
    r.scl = p.scl & (d.scl | ~d.scl_oe);
    r.sda = p.sda & (d.sda | ~d.sda_oe);
    return r;
  endfunction

  // Flags not yet reported since the last clear.
  function automatic logic [FaultWidth-1:0] new_faults(input logic [FaultWidth-1:0] flags,
                                                       input logic [FaultWidth-1:0] seen);
    return flags & ~seen;
  endfunction

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] want);
    chk_cnt++;
    if (got !== want) begin
      $display("mismatch at %0t ns: %s is 0x%0h, expected 0x%0h", $time, name, got, want);
      err_cnt++;
    end
  endtask

  task automatic compare_pins(input gpo_pins_t got, input gpo_pins_t want);
    check_val("pins_o.mb_rst", got.mb_rst, want.mb_rst);
    check_val("pins_o.mb_cs_n", got.mb_cs_n, want.mb_cs_n);
    check_val("pins_o.ard_cs_n", got.ard_cs_n, want.ard_cs_n);
    check_val("pins_o.rpi_spi1_cs_n", got.rpi_spi1_cs_n, want.rpi_spi1_cs_n);
    check_val("pins_o.rpi_spi0_cs_n", got.rpi_spi0_cs_n, want.rpi_spi0_cs_n);
    check_val("pins_o.eth_rst_n", got.eth_rst_n, want.eth_rst_n);
    check_val("pins_o.eth_cs_n", got.eth_cs_n, want.eth_cs_n);
    check_val("pins_o.flash_cs_n", got.flash_cs_n, want.flash_cs_n);
    check_val("pins_o.usr_led", got.usr_led, want.usr_led);
    check_val("pins_o.lcd_backlight", got.lcd_backlight, want.lcd_backlight);
    check_val("pins_o.lcd_dc", got.lcd_dc, want.lcd_dc);
    check_val("pins_o.lcd_rst_n", got.lcd_rst_n, want.lcd_rst_n);
    check_val("pins_o.lcd_cs_n", got.lcd_cs_n, want.lcd_cs_n);
  endtask

  task automatic end_test(input string name);
    if (err_cnt == test_err_base) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d errors", name, err_cnt - test_err_base);
    end
    test_err_base = err_cnt;
  endtask

  // New flags issue in ascending order, one per cycle.
  // First one lands two counts after its stamp.
  task automatic expect_faults(input logic [FaultWidth-1:0] flags, input logic [31:0] stamp);
    logic [FaultWidth-1:0] fresh;
    int unsigned           slot;
    exp_rec_t              e;
    fresh = new_faults(flags, model_seen);
    slot  = 0;
    for (int i = 0; i < FaultWidth; i++) begin
      if (fresh[i]) begin
        e.rec.kind  = fault_kind_e'(i);
        e.rec.stamp = stamp;
        e.at        = stamp + 2 + slot;
        exp_q.push_back(e);
        slot++;
      end
    end
    model_seen = model_seen | fresh;
  endtask

  // Flags are sampled on the edge after this one.
  task automatic drive_faults(input logic [FaultWidth-1:0] flags);
    @(posedge clk_i);
    fault_i <= flags;
    @(negedge clk_i);
    expect_faults(flags, cyc);
  endtask

  task automatic wait_records(input int unsigned limit);
    int unsigned n;
    n = 0;
    while (exp_q.size() != 0 && n < limit) begin
      @(posedge clk_i);
      n++;
    end
    if (exp_q.size() != 0) begin
      $display("timeout: %0d expected fault records never arrived", exp_q.size());
      err_cnt++;
      exp_q.delete();
    end
    // Quiet cycles to catch stray records.
    repeat (3) @(negedge clk_i);
  endtask

  // Every record against the head of the expected queue.
  always @(negedge clk_i) begin
    if (rst_ni && rec_valid_o) begin
      if (exp_q.size() == 0) begin
        $display("unexpected fault record at %0t ns: kind %0d, stamp %0d",
                 $time, rec_o.kind, rec_o.stamp);
        err_cnt++;
      end else begin
        head = exp_q.pop_front();
        check_val("rec_o.kind", rec_o.kind, head.rec.kind);
        check_val("rec_o.stamp", rec_o.stamp, head.rec.stamp);
        if (cyc != head.at) begin
          $display("fault record of kind %0d came in cycle %0d instead of cycle %0d",
                   head.rec.kind, cyc, head.at);
          err_cnt++;
        end
      end
    end
  end

  initial begin
    logic [31:0]               rng;
    logic [GpoWidth-1:0]       word;
    i2c_drive_t [I2cBuses-1:0] drv;
    i2c_line_t  [I2cBuses-1:0] pull;
    i2c_line_t  [I2cBuses-1:0] want;
    i2c_line_t  [I2cBuses-1:0] hist [$];
    logic [FaultWidth-1:0]     mask;
    int unsigned               k;

    rng           = 32'd82016;
    cyc           = '0;
    model_seen    = '0;
    chk_cnt       = 0;
    err_cnt       = 0;
    test_err_base = 0;
    rst_ni        = 1'b0;
    gp_i          = '0;
    drive_i       = '0;
    dev_pull_i    = '1;
    fault_i       = '0;
    fault_clear_i = 1'b0;

    // Idle pins have selects and mb_rst high and the rest low.
    repeat (6) @(posedge clk_i);
    @(negedge clk_i);
    compare_pins(pins_o, pin_view(23'h7F_B001));
    check_val("rec_valid_o", rec_valid_o, 1'b0);
    check_val("seen_o", seen_o, '0);
    check_val("ctrl_line_o", ctrl_line_o, {(2 * I2cBuses){1'b1}});
    repeat (2) @(posedge clk_i);
    rst_ni <= 1'b1;
    end_test("reset values");

    for (int n = 0; n < 50; n++) begin
      rng  = xorshift32(rng);
      word = rng[GpoWidth-1:0];
      @(posedge clk_i);
      gp_i <= word;
      @(posedge clk_i);
      @(negedge clk_i);
      compare_pins(pins_o, pin_view(word));
    end
    end_test("pin split");

    for (int n = 0; n < 40; n++) begin
      rng  = xorshift32(rng);
      drv  = rng[4*I2cBuses-1:0];
      // Device pull-downs mostly released.
      pull = rng[16 +: 2*I2cBuses] | rng[24 +: 2*I2cBuses];
      @(posedge clk_i);
      drive_i    <= drv;
      dev_pull_i <= pull;
      @(negedge clk_i);
      for (int b = 0; b < I2cBuses; b++) begin
        want[b] = wired_and(drv[b], pull[b]);
        check_val($sformatf("bus_o[%0d]", b), bus_o[b], want[b]);
      end
      hist.push_back(want);
      // Controller copy lags by two edges.
      if (hist.size() == 3) begin
        check_val("ctrl_line_o", ctrl_line_o, hist.pop_front());
      end
    end
    end_test("i2c resolution");

    // One fault pulsed five times.
    rng = xorshift32(rng);
    k   = rng % FaultWidth;
    for (int n = 0; n < 5; n++) begin
      drive_faults(FaultWidth'(1) << k);
      drive_faults('0);
      drive_faults('0);
    end
    wait_records(20);
    check_val("seen_o", seen_o, model_seen);
    end_test("first occurrence");

    // Bits 0, 4 and 8 forced in, so at least two are new.
    rng  = xorshift32(rng);
    mask = (rng[FaultWidth-1:0] | FaultWidth'(9'h111)) & ~model_seen;
    drive_faults(mask);
    drive_faults(mask);
    drive_faults('0);
    wait_records(FaultWidth + 10);
    check_val("seen_o", seen_o, model_seen);
    end_test("simultaneous faults");

    @(posedge clk_i);
    fault_clear_i <= 1'b1;
    @(posedge clk_i);
    fault_clear_i <= 1'b0;
    @(negedge clk_i);
    model_seen = '0;
    check_val("seen_o", seen_o, '0);
    for (int n = 0; n < 3; n++) begin
      drive_faults(FaultWidth'(1) << k);
      drive_faults('0);
    end
    wait_records(20);
    check_val("seen_o", seen_o, model_seen);
    end_test("clear");

    err_cnt += u_dut.u_fault_first_capture.u_board_harness_chk.fail_cnt;
    $display("checks %0d, errors %0d", chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
